/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := lsq_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) lsq_cfg.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+.
lsq_pkg.sv
store_queue.sv
st_fwd_search.sv
load_unit.sv
lsq_top.sv
lsq_sva.sv
lsq_tb.sv

/* load_unit.sv */
// **************************************************
// load unit: accept, forward or cache read,
// miss hold and registered completion
// **************************************************

`timescale 1ns/10ps
`include "lsq_cfg.svh"

module load_unit import lsq_pkg::*; (
	input	logic		clk,
	input	logic		rst,

	// load request
	input	logic		ld_valid_i,
	output	logic		ld_ready_o,
	input	addr_t		ld_addr_i,
	input	rob_idx_t	ld_rob_idx_i,
	input	prf_tag_t	ld_tag_i,

	// from forwarding search
	input	logic		older_unknown_i,
	input	logic		fwd_hit_i,
	input	data_t		fwd_data_i,

	// cache read
	output	logic		rd_req_valid_o,
	input	logic		rd_req_ready_i,
	output	addr_t		rd_req_addr_o,
	input	logic		rd_resp_valid_i,
	input	data_t		rd_resp_data_i,

	// completion
	output	logic		ld_done_o,
	output	data_t		ld_data_o,
	output	rob_idx_t	ld_rob_idx_o,
	output	prf_tag_t	ld_tag_o
);

	ld_state_e	state_q;
	ld_state_e	state_d;
	logic		done_q;
	addr_t		addr_q;
	rob_idx_t	rob_idx_q;
	prf_tag_t	tag_q;
	data_t		data_q;

	logic		ld_accept;
	logic		fwd_done;
	logic		resp_done;

	// issue only with every older store address known
	assign ld_ready_o = (state_q == LD_IDLE) & ~older_unknown_i;
	assign ld_accept = ld_valid_i & ld_ready_o;
	assign fwd_done = ld_accept & fwd_hit_i;
	assign resp_done = (state_q == LD_WAIT_RESP) & rd_resp_valid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			LD_IDLE: begin
				if (ld_accept && !fwd_hit_i)
					state_d = LD_WAIT_REQ;
			end
			LD_WAIT_REQ: begin
				if (rd_req_ready_i)
					state_d = LD_WAIT_RESP;
			end
			LD_WAIT_RESP: begin
				if (rd_resp_valid_i)
					state_d = LD_IDLE;
			end
			default: state_d = LD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= LD_IDLE;
			done_q <= 1'b0;
		end else begin
			state_q <= state_d;
			done_q <= fwd_done | resp_done;
		end
	end

	// held load, also the miss address
	always_ff @(posedge clk) begin
		if (ld_accept) begin
			addr_q <= ld_addr_i;
			rob_idx_q <= ld_rob_idx_i;
			tag_q <= ld_tag_i;
		end
		if (fwd_done)
			data_q <= fwd_data_i;
		else if (resp_done)
			data_q <= rd_resp_data_i;
	end

	assign rd_req_valid_o = (state_q == LD_WAIT_REQ);
	assign rd_req_addr_o = addr_q;

	assign ld_done_o = done_q;
	assign ld_data_o = data_q;
	assign ld_rob_idx_o = rob_idx_q;
	assign ld_tag_o = tag_q;

endmodule

/* lsq_cfg.svh */
// **************************************************
// store queue depth and field width defines
// **************************************************

`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// store queue geometry, entries must be 2**idx width
`define LSQ_SQ_ENT_NUM	8
`define LSQ_SQ_IDX_W	3

// memory fields
`define LSQ_ADDR_W		32
`define LSQ_DATA_W		64

// core tags
`define LSQ_ROB_IDX_W	5
`define LSQ_PRF_IDX_W	6

`endif

/* lsq_pkg.sv */
// **************************************************
// load/store queue shared types
// vector typedefs and the load unit state enum
// **************************************************

`include "lsq_cfg.svh"

package lsq_pkg;

	typedef logic [`LSQ_ADDR_W-1:0]		addr_t;
	typedef logic [`LSQ_DATA_W-1:0]		data_t;

	// slot index, and slot index with wrap bit on top
	typedef logic [`LSQ_SQ_IDX_W-1:0]	sq_idx_t;
	typedef logic [`LSQ_SQ_IDX_W:0]		sq_ptr_t;

	typedef logic [`LSQ_ROB_IDX_W-1:0]	rob_idx_t;
	typedef logic [`LSQ_PRF_IDX_W-1:0]	prf_tag_t;

	typedef enum logic [1:0] {
		LD_IDLE			= 2'd0,
		LD_WAIT_REQ		= 2'd1,
		LD_WAIT_RESP	= 2'd2
	} ld_state_e;

endpackage

/* lsq_sva.sv */
// **************************************************
// handshake stability and completion pulse checks
// **************************************************

`timescale 1ns/10ps

module lsq_sva import lsq_pkg::*; (
	input	logic	clk,
	input	logic	rst,
	input	logic	st_valid_i,
	input	logic	st_ready_i,
	input	addr_t	st_addr_i,
	input	data_t	st_data_i,
	input	logic	rd_valid_i,
	input	logic	rd_ready_i,
	input	addr_t	rd_addr_i,
	input	logic	done_i
);

	// stalled drain keeps valid and payload
	a_st_req_hold: assert property (@(posedge clk) disable iff (rst)
		st_valid_i && !st_ready_i |=> st_valid_i && $stable(st_addr_i) && $stable(st_data_i))
		else $error("store request dropped or changed while stalled");

	a_rd_req_hold: assert property (@(posedge clk) disable iff (rst)
		rd_valid_i && !rd_ready_i |=> rd_valid_i && $stable(rd_addr_i))
		else $error("read request dropped or changed while stalled");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done_i |=> !done_i)
		else $error("load completion longer than one cycle");

endmodule

bind lsq_top lsq_sva u_lsq_sva (
	.clk		(clk),
	.rst		(rst),
	.st_valid_i	(st_req_valid_o),
	.st_ready_i	(st_req_ready_i),
	.st_addr_i	(st_req_addr_o),
	.st_data_i	(st_req_data_o),
	.rd_valid_i	(rd_req_valid_o),
	.rd_ready_i	(rd_req_ready_i),
	.rd_addr_i	(rd_req_addr_o),
	.done_i		(ld_done_o)
);

/* lsq_tb.sv */
// **************************************************
// directed testbench for lsq_top
// cache memory model, checks and timeout
// **************************************************

`timescale 1ns/10ps
`include "lsq_cfg.svh"

module lsq_tb import lsq_pkg::*; ();

	localparam int			TIMEOUT_CYCLES = 4000;
	localparam logic [31:0]	SEED = 32'h27ce_88b0;

	logic		clk = 1'b0;
	logic		rst;
	logic		dp_valid_i;
	logic		dp_ready_o;
	sq_ptr_t	sq_tail_o;
	logic		st_wr_i;
	sq_idx_t	st_idx_i;
	addr_t		st_addr_i;
	data_t		st_data_i;
	logic		rob_st_retire_i;
	logic		st_req_valid_o;
	logic		st_req_ready_i = 1'b0;
	addr_t		st_req_addr_o;
	data_t		st_req_data_o;
	logic		ld_valid_i;
	logic		ld_ready_o;
	addr_t		ld_addr_i;
	rob_idx_t	ld_rob_idx_i;
	prf_tag_t	ld_tag_i;
	sq_ptr_t	ld_sq_pos_i;
	logic		rd_req_valid_o;
	logic		rd_req_ready_i = 1'b0;
	addr_t		rd_req_addr_o;
	logic		rd_resp_valid_i = 1'b0;
	data_t		rd_resp_data_i = '0;
	logic		ld_done_o;
	data_t		ld_data_o;
	rob_idx_t	ld_rob_idx_o;
	prf_tag_t	ld_tag_o;

	// cache model state
	data_t			mem [addr_t];
	addr_t			drain_addr_q [$];
	data_t			drain_data_q [$];
	logic [31:0]	rnd = SEED;
	addr_t			rd_addr = '0;
	int				rd_wait = 0;

	// expected drains in allocation order
	addr_t			exp_addr_q [$];
	data_t			exp_data_q [$];
	int				drain_base = 0;
	int				cycles = 0;

	lsq_top uut (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// untouched words hold a pattern of the full address
	function automatic data_t mem_read(input addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {~a, a ^ 32'h9e37_79b9};
	endfunction

	// **************************************************
	// cache model
	// **************************************************

	// handshakes sampled at negedge and responses driven after posedge
	always begin
		@(negedge clk);
		if (st_req_valid_o && st_req_ready_i) begin
			drain_addr_q.push_back(st_req_addr_o);
			drain_data_q.push_back(st_req_data_o);
			mem[st_req_addr_o] = st_req_data_o;
		end
		if (rd_req_valid_o && rd_req_ready_i) begin
			rd_addr = rd_req_addr_o;
			rd_wait = 1 + int'(rnd[5:4]);
		end
		@(posedge clk);
		#1;
		rnd = xorshift(rnd);
		st_req_ready_i = rnd[0] | rnd[1];
		rd_req_ready_i = rnd[2] | rnd[3];
		rd_resp_valid_i = 1'b0;
		if (rd_wait > 0) begin
			rd_wait = rd_wait - 1;
			if (rd_wait == 0) begin
				rd_resp_valid_i = 1'b1;
				rd_resp_data_i = mem_read(rd_addr);
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	// **************************************************
	// helpers
	// **************************************************

	task automatic check_eq(input string what, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			$display("** Error at %0t: %s, got %h, expected %h", $time, what, got, want);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic alloc_store(output sq_ptr_t ptr);
		sq_ptr_t next_ptr;
		while (!dp_ready_o)
			step();
		ptr = sq_tail_o;
		next_ptr = ptr + sq_ptr_t'(1);
		dp_valid_i = 1'b1;
		step();
		dp_valid_i = 1'b0;
		check_eq("tail advance", 64'(sq_tail_o), 64'(next_ptr));
	endtask

	task automatic write_store(input sq_ptr_t ptr, input addr_t a, input data_t d);
		st_wr_i = 1'b1;
		st_idx_i = ptr[`LSQ_SQ_IDX_W-1:0];
		st_addr_i = a;
		st_data_i = d;
		step();
		st_wr_i = 1'b0;
	endtask

	task automatic put_store(input addr_t a, input data_t d);
		sq_ptr_t p;
		alloc_store(p);
		write_store(p, a, d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	task automatic retire(input int n);
		rob_st_retire_i = 1'b1;
		repeat (n) step();
		rob_st_retire_i = 1'b0;
	endtask

	task automatic drain_compare(input int n);
		while (drain_addr_q.size() < drain_base + n)
			step();
		repeat (4) step();
		check_eq("drain count", 64'(drain_addr_q.size()), 64'(drain_base + n));
		for (int k = 0; k < n; k++) begin
			check_eq("drain addr", 64'(drain_addr_q[drain_base + k]), 64'(exp_addr_q[k]));
			check_eq("drain data", drain_data_q[drain_base + k], exp_data_q[k]);
		end
		drain_base += n;
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic issue_load(input addr_t a, input rob_idx_t rob, input prf_tag_t tag,
			input sq_ptr_t pos, input logic hit, input data_t want);
		logic resp_prev;
		resp_prev = 1'b0;
		ld_valid_i = 1'b1;
		ld_addr_i = a;
		ld_rob_idx_i = rob;
		ld_tag_i = tag;
		ld_sq_pos_i = pos;
		@(negedge clk);
		while (!ld_ready_o) begin
			step();
			@(negedge clk);
		end
		// accepted on this edge
		step();
		ld_valid_i = 1'b0;
		@(negedge clk);
		check_eq("cache read request", 64'(rd_req_valid_o), 64'(!hit));
		if (!hit) begin
			check_eq("cache read address", 64'(rd_req_addr_o), 64'(a));
			while (!ld_done_o) begin
				resp_prev = rd_resp_valid_i;
				@(negedge clk);
			end
			check_eq("done after response", 64'(resp_prev), 64'd1);
		end
		check_eq("load done", 64'(ld_done_o), 64'd1);
		check_eq("load data", ld_data_o, want);
		check_eq("load rob index", 64'(ld_rob_idx_o), 64'(rob));
		check_eq("load tag", 64'(ld_tag_o), 64'(tag));
		step();
	endtask

	// **************************************************
	// tests
	// **************************************************

	task automatic reset_and_fill();
		sq_ptr_t p;
		check_eq("ready after reset", 64'(dp_ready_o), 64'd1);
		check_eq("tail after reset", 64'(sq_tail_o), 64'd0);
		check_eq("valids after reset",
				64'({st_req_valid_o, rd_req_valid_o, ld_done_o}), 64'd0);
		check_eq("load ready after reset", 64'(ld_ready_o), 64'd1);
		for (int i = 0; i < `LSQ_SQ_ENT_NUM; i++) begin
			alloc_store(p);
			check_eq("fill slot", 64'(p), 64'(i));
		end
		check_eq("full", 64'(dp_ready_o), 64'd0);
	endtask

	task automatic in_order_drain();
		int order [8] = '{5, 2, 7, 0, 3, 6, 1, 4};
		for (int i = 0; i < 8; i++) begin
			exp_addr_q.push_back(32'h1000 + 32'(i * 8));
			exp_data_q.push_back({32'hd0d0_0000 | 32'(i), 32'h1000 + 32'(i * 8)});
		end
		for (int i = 0; i < 8; i++)
			write_store(sq_ptr_t'(order[i]), exp_addr_q[order[i]], exp_data_q[order[i]]);
		check_eq("no drain before retire", 64'(st_req_valid_o), 64'd0);
		retire(8);
		while (drain_addr_q.size() < drain_base + 1)
			step();
		check_eq("ready after first drain", 64'(dp_ready_o), 64'd1);
		drain_compare(8);
	endtask

	task automatic forward_youngest();
		put_store(32'h2000, 64'h1111_0000_0000_2000);
		put_store(32'h2000, 64'h2222_0000_0000_2000);
		issue_load(32'h2000, 5'd3, 6'd17, sq_tail_o, 1'b1, 64'h2222_0000_0000_2000);
		retire(2);
		drain_compare(2);
	endtask

	task automatic skip_younger_store();
		sq_ptr_t pos;
		data_t want;
		put_store(32'h3000, 64'h3333_0000_0000_3000);
		pos = sq_tail_o;
		put_store(32'h2000, 64'h4444_0000_0000_2000);
		want = mem_read(32'h2000);
		issue_load(32'h2000, 5'd4, 6'd21, pos, 1'b0, want);
		retire(2);
		drain_compare(2);
	endtask

	task automatic hold_for_unknown_addr();
		sq_ptr_t p;
		alloc_store(p);
		ld_valid_i = 1'b1;
		ld_addr_i = 32'h4000;
		ld_rob_idx_i = 5'd6;
		ld_tag_i = 6'd33;
		ld_sq_pos_i = sq_tail_o;
		repeat (4) begin
			@(negedge clk);
			check_eq("load held by unknown address", 64'(ld_ready_o), 64'd0);
			step();
		end
		write_store(p, 32'h4000, 64'h5555_0000_0000_4000);
		exp_addr_q.push_back(32'h4000);
		exp_data_q.push_back(64'h5555_0000_0000_4000);
		issue_load(32'h4000, 5'd6, 6'd33, ld_sq_pos_i, 1'b1, 64'h5555_0000_0000_4000);
		retire(1);
		drain_compare(1);
	endtask

	task automatic wrap_around();
		sq_ptr_t mid;
		put_store(32'h5000, 64'h6000_0000_0000_0000);
		put_store(32'h6000, 64'h6000_0000_0000_0001);
		put_store(32'h5008, 64'h6000_0000_0000_0002);
		// thirteen earlier stores put the tail back at slot 0
		mid = sq_tail_o;
		check_eq("tail wrapped", 64'(mid), 64'd0);
		put_store(32'h7000, 64'h6000_0000_0000_0003);
		put_store(32'h6000, 64'h6000_0000_0000_0004);
		put_store(32'h5010, 64'h6000_0000_0000_0005);
		issue_load(32'h6000, 5'd7, 6'd40, mid, 1'b1, 64'h6000_0000_0000_0001);
		issue_load(32'h6000, 5'd8, 6'd41, sq_tail_o, 1'b1, 64'h6000_0000_0000_0004);
		retire(6);
		drain_compare(6);
	endtask

	initial begin
		rst = 1'b1;
		dp_valid_i = 1'b0;
		st_wr_i = 1'b0;
		st_idx_i = '0;
		st_addr_i = '0;
		st_data_i = '0;
		rob_st_retire_i = 1'b0;
		ld_valid_i = 1'b0;
		ld_addr_i = '0;
		ld_rob_idx_i = '0;
		ld_tag_i = '0;
		ld_sq_pos_i = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_and_fill();
		in_order_drain();
		forward_youngest();
		skip_younger_store();
		hold_for_unknown_addr();
		wrap_around();
		$display("All checks passed");
		$finish;
	end

endmodule

/* lsq_top.sv */
// **************************************************
// store queue with store-to-load forwarding, top
// **************************************************

`timescale 1ns/10ps
`include "lsq_cfg.svh"

module lsq_top import lsq_pkg::*; (
	input	logic		clk,
	input	logic		rst,

	// dispatch
	input	logic		dp_valid_i,
	output	logic		dp_ready_o,
	output	sq_ptr_t	sq_tail_o,

	// store address/data write
	input	logic		st_wr_i,
	input	sq_idx_t	st_idx_i,
	input	addr_t		st_addr_i,
	input	data_t		st_data_i,

	input	logic		rob_st_retire_i,

	// store drain
	output	logic		st_req_valid_o,
	input	logic		st_req_ready_i,
	output	addr_t		st_req_addr_o,
	output	data_t		st_req_data_o,

	// load request
	input	logic		ld_valid_i,
	output	logic		ld_ready_o,
	input	addr_t		ld_addr_i,
	input	rob_idx_t	ld_rob_idx_i,
	input	prf_tag_t	ld_tag_i,
	input	sq_ptr_t	ld_sq_pos_i,

	// cache read
	output	logic		rd_req_valid_o,
	input	logic		rd_req_ready_i,
	output	addr_t		rd_req_addr_o,
	input	logic		rd_resp_valid_i,
	input	data_t		rd_resp_data_i,

	// load completion
	output	logic		ld_done_o,
	output	data_t		ld_data_o,
	output	rob_idx_t	ld_rob_idx_o,
	output	prf_tag_t	ld_tag_o
);

	sq_ptr_t							sq_head;
	logic	[`LSQ_SQ_ENT_NUM-1:0]		sq_addr_vld;
	addr_t	[`LSQ_SQ_ENT_NUM-1:0]		sq_addr;
	data_t	[`LSQ_SQ_ENT_NUM-1:0]		sq_data;
	logic								older_unknown;
	logic								fwd_hit;
	data_t								fwd_data;

	store_queue u_store_queue (
		.clk				(clk),
		.rst				(rst),
		.dp_valid_i			(dp_valid_i),
		.dp_ready_o			(dp_ready_o),
		.sq_tail_o			(sq_tail_o),
		.st_wr_i			(st_wr_i),
		.st_idx_i			(st_idx_i),
		.st_addr_i			(st_addr_i),
		.st_data_i			(st_data_i),
		.rob_st_retire_i	(rob_st_retire_i),
		.sq_head_o			(sq_head),
		.sq_addr_vld_o		(sq_addr_vld),
		.sq_addr_o			(sq_addr),
		.sq_data_o			(sq_data),
		.st_req_valid_o		(st_req_valid_o),
		.st_req_ready_i		(st_req_ready_i),
		.st_req_addr_o		(st_req_addr_o),
		.st_req_data_o		(st_req_data_o)
	);

	st_fwd_search u_st_fwd_search (
		.sq_head_i			(sq_head),
		.ld_sq_pos_i		(ld_sq_pos_i),
		.ld_addr_i			(ld_addr_i),
		.sq_addr_vld_i		(sq_addr_vld),
		.sq_addr_i			(sq_addr),
		.sq_data_i			(sq_data),
		.older_unknown_o	(older_unknown),
		.fwd_hit_o			(fwd_hit),
		.fwd_data_o			(fwd_data)
	);

	load_unit u_load_unit (
		.clk				(clk),
		.rst				(rst),
		.ld_valid_i			(ld_valid_i),
		.ld_ready_o			(ld_ready_o),
		.ld_addr_i			(ld_addr_i),
		.ld_rob_idx_i		(ld_rob_idx_i),
		.ld_tag_i			(ld_tag_i),
		.older_unknown_i	(older_unknown),
		.fwd_hit_i			(fwd_hit),
		.fwd_data_i			(fwd_data),
		.rd_req_valid_o		(rd_req_valid_o),
		.rd_req_ready_i		(rd_req_ready_i),
		.rd_req_addr_o		(rd_req_addr_o),
		.rd_resp_valid_i	(rd_resp_valid_i),
		.rd_resp_data_i		(rd_resp_data_i),
		.ld_done_o			(ld_done_o),
		.ld_data_o			(ld_data_o),
		.ld_rob_idx_o		(ld_rob_idx_o),
		.ld_tag_o			(ld_tag_o)
	);

endmodule

/* st_fwd_search.sv */
// **************************************************
// age check and store-to-load forwarding search
// **************************************************

`timescale 1ns/10ps
`include "lsq_cfg.svh"

module st_fwd_search import lsq_pkg::*; (
	input	sq_ptr_t							sq_head_i,
	input	sq_ptr_t							ld_sq_pos_i,
	input	addr_t								ld_addr_i,
	input	logic	[`LSQ_SQ_ENT_NUM-1:0]		sq_addr_vld_i,
	input	addr_t	[`LSQ_SQ_ENT_NUM-1:0]		sq_addr_i,
	input	data_t	[`LSQ_SQ_ENT_NUM-1:0]		sq_data_i,

	output	logic								older_unknown_o,
	output	logic								fwd_hit_o,
	output	data_t								fwd_data_o
);

	sq_ptr_t	pos_dist;
	sq_ptr_t	older_cnt;

	// stores older than the load, wrap bits keep 0 and 8 apart
	assign pos_dist = ld_sq_pos_i - sq_head_i;

	// head already past the load position, all older stores drained
	assign older_cnt = (pos_dist > sq_ptr_t'(`LSQ_SQ_ENT_NUM)) ? '0 : pos_dist;

	// walk from head toward the load, later match is younger and wins
	always_comb begin
		sq_idx_t	slot;

		older_unknown_o = 1'b0;
		fwd_hit_o = 1'b0;
		fwd_data_o = '0;
		for (int k = 0; k < `LSQ_SQ_ENT_NUM; k++) begin
			slot = sq_head_i[`LSQ_SQ_IDX_W-1:0] + sq_idx_t'(k);
			if (sq_ptr_t'(k) < older_cnt) begin
				if (!sq_addr_vld_i[slot]) begin
					older_unknown_o = 1'b1;
				end else if (sq_addr_i[slot] == ld_addr_i) begin
					fwd_hit_o = 1'b1;
					fwd_data_o = sq_data_i[slot];
				end
			end
		end
	end

endmodule

/* store_queue.sv */
// **************************************************
// circular store buffer with retire tracking
// and in-order drain to the data cache write port
// **************************************************

`timescale 1ns/10ps
`include "lsq_cfg.svh"

module store_queue import lsq_pkg::*; (
	input	logic								clk,
	input	logic								rst,

	// dispatch
	input	logic								dp_valid_i,
	output	logic								dp_ready_o,
	output	sq_ptr_t							sq_tail_o,

	// address/data write by slot
	input	logic								st_wr_i,
	input	sq_idx_t							st_idx_i,
	input	addr_t								st_addr_i,
	input	data_t								st_data_i,

	// reorder buffer retire strobe
	input	logic								rob_st_retire_i,

	// entry view for the forwarding search
	output	sq_ptr_t							sq_head_o,
	output	logic	[`LSQ_SQ_ENT_NUM-1:0]		sq_addr_vld_o,
	output	addr_t	[`LSQ_SQ_ENT_NUM-1:0]		sq_addr_o,
	output	data_t	[`LSQ_SQ_ENT_NUM-1:0]		sq_data_o,

	// cache write port
	output	logic								st_req_valid_o,
	input	logic								st_req_ready_i,
	output	addr_t								st_req_addr_o,
	output	data_t								st_req_data_o
);

	// **************************************************
	// state
	// **************************************************

	// head: oldest live entry, ret: first not yet retired, tail: next free
	sq_ptr_t							head_q;
	sq_ptr_t							ret_q;
	sq_ptr_t							tail_q;

	logic	[`LSQ_SQ_ENT_NUM-1:0]		addr_vld_q;
	addr_t	[`LSQ_SQ_ENT_NUM-1:0]		addr_q;
	data_t	[`LSQ_SQ_ENT_NUM-1:0]		data_q;

	sq_idx_t							head_idx;
	sq_idx_t							tail_idx;
	logic								sq_full;
	logic								head_retired;
	logic								alloc;
	logic								drain;

	// **************************************************
	// pointer compare and handshakes
	// **************************************************

	assign head_idx = head_q[`LSQ_SQ_IDX_W-1:0];
	assign tail_idx = tail_q[`LSQ_SQ_IDX_W-1:0];

	// same slot, wrap bits differ
	assign sq_full = (head_idx == tail_idx) &&
					 (head_q[`LSQ_SQ_IDX_W] != tail_q[`LSQ_SQ_IDX_W]);

	// anything between head and retire pointer is committed
	assign head_retired = (head_q != ret_q);

	assign dp_ready_o = ~sq_full;
	assign alloc = dp_valid_i & dp_ready_o;

	assign st_req_valid_o = head_retired & addr_vld_q[head_idx];
	assign st_req_addr_o = addr_q[head_idx];
	assign st_req_data_o = data_q[head_idx];
	assign drain = st_req_valid_o & st_req_ready_i;

	assign sq_tail_o = tail_q;
	assign sq_head_o = head_q;
	assign sq_addr_vld_o = addr_vld_q;
	assign sq_addr_o = addr_q;
	assign sq_data_o = data_q;

	// **************************************************
	// pointers
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			ret_q <= '0;
			tail_q <= '0;
		end else begin
			if (alloc)
				tail_q <= tail_q + sq_ptr_t'(1);
			if (rob_st_retire_i)
				ret_q <= ret_q + sq_ptr_t'(1);
			// head advance frees the slot
			if (drain)
				head_q <= head_q + sq_ptr_t'(1);
		end
	end

	// **************************************************
	// entries
	// **************************************************

	// new store starts with unknown address
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_vld_q <= '0;
		end else begin
			if (alloc)
				addr_vld_q[tail_idx] <= 1'b0;
			if (st_wr_i)
				addr_vld_q[st_idx_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (st_wr_i) begin
			addr_q[st_idx_i] <= st_addr_i;
			data_q[st_idx_i] <= st_data_i;
		end
	end

endmodule
